/* design/rvPkg.sv */
// Shared widths, ALU-op encoding and pipeline payload for the RV32I subset core; import it
package rvPkg;

	// ========================================
	// Basic widths
	// ========================================
	typedef logic [31:0] wordT;      // Data or instruction word
	typedef logic [4:0]  regAddrT;
	typedef logic [29:0] wordAddrT;  // Byte address without bits [1:0]

	// Low three bits pick the function, bit 3 picks sub/sra
	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSub = 4'b1000,
		aluSll = 4'b0001,
		aluSlt = 4'b0010,
		aluXor = 4'b0100,
		aluSrl = 4'b0101,
		aluSra = 4'b1101,
		aluOr  = 4'b0110,
		aluAnd = 4'b0111
	} aluOpT;

	// Decode to execute payload
	typedef struct packed {
		aluOpT   aluOp;
		wordT    rs1Val;
		wordT    rs2Val;
		wordT    imm;
		logic    useImm;    // Operand B from imm
		logic    regWrite;
		logic    memWrite;
		regAddrT rd;
	} execOpT;

	// ========================================
	// Opcodes and bubbles
	// ========================================
	localparam logic [6:0] opReg   = 7'b0110011;
	localparam logic [6:0] opImm   = 7'b0010011;
	localparam logic [6:0] opStore = 7'b0100011;

	localparam wordT nopInstr = 32'h0000_0013;  // addi x0, x0, 0

	localparam execOpT execBubble = '{aluOp: aluAdd, rs1Val: '0, rs2Val: '0, imm: '0,
		useImm: 1'b0, regWrite: 1'b0, memWrite: 1'b0, rd: '0};

	// Memory side is little endian, core is big endian
	function automatic wordT swapBytes(input wordT w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

/* design/pipeStage.sv */
// Generic pipeline register; captures a payload when loaded, otherwise inserts a bubble
`timescale 1ns/1ps

module pipeStage #(
	parameter type     PayloadT    = logic [31:0],
	parameter PayloadT BubbleValue = '0
) (
	input  logic    clk,
	input  logic    rst_n,
	input  logic    load,        // Payload valid this cycle
	input  PayloadT inPayload,
	output PayloadT outPayload
);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			outPayload <= BubbleValue;
		end else if (load) begin
			outPayload <= inPayload;
		end else begin
			// Nothing valid upstream, keep the pipe moving with a bubble
			outPayload <= BubbleValue;
		end
	end

endmodule

/* design/rvFetch.sv */
// Fetch stage; owns the word PC, drives the instruction port and reorders fetched bytes
`timescale 1ns/1ps

module rvFetch import rvPkg::*; #(
	parameter wordAddrT ResetPc = '0
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     instStall,
	input  wordT     instRdata,
	output logic     instRead,
	output wordAddrT instAddr,
	output wordT     fetchWord,
	output logic     fetchValid
);

	wordAddrT pc;

	// Word accepted on any edge with the port idle
	assign fetchValid = instRead & ~instStall;
	assign fetchWord  = swapBytes(instRdata);  // Little to big endian
	assign instAddr   = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc       <= ResetPc;
			instRead <= 1'b0;
		end else begin
			instRead <= 1'b1;
			if (fetchValid) begin
				pc <= pc + wordAddrT'(1);  // Next word
			end
		end
	end

endmodule

/* design/rvDecode.sv */
// Decode stage; turns one instruction plus register values into an execute payload
`timescale 1ns/1ps

module rvDecode import rvPkg::*; (
	input  wordT    instr,
	output regAddrT rs1Addr,
	output regAddrT rs2Addr,
	input  wordT    rs1Data,
	input  wordT    rs2Data,
	output execOpT  execOp,
	output logic    legal
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       altFn;       // funct7 bit 5
	logic       isShiftImm;
	wordT       immI;
	wordT       immS;
	wordT       immShamt;

	aluOpT      aluSel;
	wordT       imm;
	logic       useImm;
	logic       regWrite;
	logic       memWrite;

	// ========================================
	// Field extraction
	// ========================================
	assign opcode  = instr[6:0];
	assign funct3  = instr[14:12];
	assign altFn   = instr[30];
	assign rs1Addr = instr[19:15];
	assign rs2Addr = instr[24:20];

	assign isShiftImm = (funct3 == 3'b001) || (funct3 == 3'b101);

	assign immI     = {{20{instr[31]}}, instr[31:20]};
	assign immS     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immShamt = {27'b0, instr[24:20]};

	// ========================================
	// Control and ALU op
	// ========================================
	always_comb begin
		legal    = 1'b1;
		aluSel   = aluAdd;
		imm      = '0;
		useImm   = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		case (opcode)
			opReg: begin
				aluSel   = aluOpT'({altFn, funct3});
				regWrite = 1'b1;
			end
			opImm: begin
				// Only srai keeps the funct7 bit, it is part of the immediate otherwise
				aluSel   = aluOpT'({altFn & (funct3 == 3'b101), funct3});
				imm      = isShiftImm ? immShamt : immI;
				useImm   = 1'b1;
				regWrite = 1'b1;
			end
			opStore: begin
				imm      = immS;  // Address = rs1 + imm, ALU adds
				useImm   = 1'b1;
				memWrite = 1'b1;
			end
			default: legal = 1'b0;  // Dropped or unknown opcode
		endcase
	end

	assign execOp = '{aluOp: aluSel, rs1Val: rs1Data, rs2Val: rs2Data, imm: imm,
		useImm: useImm, regWrite: regWrite, memWrite: memWrite, rd: instr[11:7]};

endmodule

/* design/rvRegFile.sv */
// Integer register file, 32 x 32 bit, x0 reads zero, same-cycle write is bypassed to reads
`timescale 1ns/1ps

module rvRegFile import rvPkg::*; (
	input  logic    clk,
	input  logic    rst_n,
	input  regAddrT rs1Addr,
	input  regAddrT rs2Addr,
	output wordT    rs1Data,
	output wordT    rs2Data,
	input  logic    wbEn,
	input  regAddrT wbAddr,
	input  wordT    wbData
);

	wordT regs [32];
	logic wbLive;    // A real write this cycle

	assign wbLive = wbEn && (wbAddr != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbLive) begin
			regs[wbAddr] <= wbData;
		end
	end

	// Bypass covers the only dependency left in a two-stage back end
	assign rs1Data = (wbLive && (wbAddr == rs1Addr)) ? wbData : regs[rs1Addr];
	assign rs2Data = (wbLive && (wbAddr == rs2Addr)) ? wbData : regs[rs2Addr];

endmodule

/* design/rvExecute.sv */
// Execute stage; ALU, register write-back request and the store-word port
`timescale 1ns/1ps

module rvExecute import rvPkg::*; (
	input  execOpT   execOp,
	output logic     wbEn,
	output regAddrT  wbAddr,
	output wordT     wbData,
	output logic     dataWen,
	output wordAddrT dataAddr,
	output wordT     dataWdata
);

	wordT       opA;
	wordT       opB;
	logic [4:0] shamt;
	wordT       result;

	// ========================================
	// ALU
	// ========================================
	assign opA   = execOp.rs1Val;
	assign opB   = execOp.useImm ? execOp.imm : execOp.rs2Val;
	assign shamt = opB[4:0];  // RV32 shifts use five bits

	always_comb begin
		case (execOp.aluOp)
			aluAdd:  result = opA + opB;
			aluSub:  result = opA - opB;
			aluSll:  result = opA << shamt;
			aluSlt:  result = {31'b0, $signed(opA) < $signed(opB)};
			aluXor:  result = opA ^ opB;
			aluSrl:  result = opA >> shamt;
			aluSra:  result = $unsigned($signed(opA) >>> shamt);
			aluOr:   result = opA | opB;
			aluAnd:  result = opA & opB;
			default: result = '0;  // sltu and other unused codes
		endcase
	end

	// ========================================
	// Write-back and store
	// ========================================
	assign wbEn   = execOp.regWrite;
	assign wbAddr = execOp.rd;
	assign wbData = result;

	assign dataWen   = execOp.memWrite;
	assign dataAddr  = result[31:2];                  // Word address
	assign dataWdata = swapBytes(execOp.rs2Val);      // Memory is little endian

endmodule

/* design/rvCore.sv */
// Top level of the RV32I subset core; instantiate with an instruction port and a store port
`timescale 1ns/1ps

module rvCore import rvPkg::*; #(
	parameter wordAddrT ResetPc = '0
) (
	input  logic     clk,
	input  logic     rst_n,
	output logic     instRead,
	output wordAddrT instAddr,
	input  wordT     instRdata,
	input  logic     instStall,
	output logic     dataWen,
	output wordAddrT dataAddr,
	output wordT     dataWdata
);

	wordT    fetchWord;
	logic    fetchValid;
	wordT    decInstr;     // Fetch/decode buffer output
	regAddrT rs1Addr;
	regAddrT rs2Addr;
	wordT    rs1Data;
	wordT    rs2Data;
	execOpT  decOp;
	logic    decLegal;
	execOpT  exOp;         // Decode/execute buffer output
	logic    wbEn;
	regAddrT wbAddr;
	wordT    wbData;

	// ========================================
	// Fetch and fetch/decode buffer
	// ========================================
	rvFetch #(.ResetPc(ResetPc)) i_rvFetch (
		.clk(clk), .rst_n(rst_n), .instStall(instStall), .instRdata(instRdata),
		.instRead(instRead), .instAddr(instAddr),
		.fetchWord(fetchWord), .fetchValid(fetchValid)
	);

	// Stalled fetch turns into a nop here
	pipeStage #(.PayloadT(wordT), .BubbleValue(nopInstr)) i_fetchStage (
		.clk(clk), .rst_n(rst_n), .load(fetchValid),
		.inPayload(fetchWord), .outPayload(decInstr)
	);

	// ========================================
	// Decode, registers, execute
	// ========================================
	rvDecode i_rvDecode (
		.instr(decInstr), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
		.rs1Data(rs1Data), .rs2Data(rs2Data), .execOp(decOp), .legal(decLegal)
	);

	rvRegFile i_rvRegFile (
		.clk(clk), .rst_n(rst_n), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
		.rs1Data(rs1Data), .rs2Data(rs2Data),
		.wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData)
	);

	pipeStage #(.PayloadT(execOpT), .BubbleValue(execBubble)) i_execStage (
		.clk(clk), .rst_n(rst_n), .load(decLegal),  // Illegal words become bubbles
		.inPayload(decOp), .outPayload(exOp)
	);

	rvExecute i_rvExecute (
		.execOp(exOp), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
		.dataWen(dataWen), .dataAddr(dataAddr), .dataWdata(dataWdata)
	);

endmodule

/* tests/rvCore_properties.sv */
// Concurrent checks on the core's instruction and store ports, bound onto rvCore
`timescale 1ns/1ps

module rvCore_properties import rvPkg::*; (
	input logic     clk,
	input logic     rst_n,
	input logic     instRead,
	input wordAddrT instAddr,
	input logic     instStall,
	input logic     dataWen
);

	int failCount = 0;  // Failed assertions so far

	// Both enables quiet after any reset edge
	resetQuiet: assert property (@(posedge clk) !rst_n |=> (!dataWen && !instRead))
		else begin
			failCount++;
			$error("dataWen or instRead high during reset");
		end

	stallHoldsPc: assert property (@(posedge clk) disable iff (!rst_n)
		instStall |=> $stable(instAddr))
		else begin
			failCount++;
			$error("instAddr moved across a stalled edge");
		end

	fetchAdvancesPc: assert property (@(posedge clk) disable iff (!rst_n)
		(instRead && !instStall) |=> instAddr == $past(instAddr) + wordAddrT'(1))
		else begin
			failCount++;
			$error("instAddr did not advance by one word after a fetch");
		end

endmodule

bind rvCore rvCore_properties i_rvCoreProperties (.*);

/* tests/rvCoreTb.sv */
// Testbench for rvCore; runs the program from the stim file and checks every stored word
`timescale 1ns/1ps

module rvCoreTb import rvPkg::*; ();

	logic     clk;
	logic     rst_n;
	logic     instRead;
	wordAddrT instAddr;
	wordT     instRdata = nopInstr;
	logic     instStall = 1'b1;
	logic     dataWen;
	wordAddrT dataAddr;
	wordT     dataWdata;

	wordT     progWords[$];      // Big-endian program
	wordAddrT expAddr[$];
	wordT     expData[$];        // Value as held in the register
	int       stallDraw[1024];   // Stall gap per accepted word, zero means streaming
	int       drawIdx = 0;
	int       stallLeft = 0;
	int       storeCount = 0;

	rvCore #(.ResetPc('0)) i_rvCore (
		.clk(clk), .rst_n(rst_n), .instRead(instRead), .instAddr(instAddr),
		.instRdata(instRdata), .instStall(instStall),
		.dataWen(dataWen), .dataAddr(dataAddr), .dataWdata(dataWdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	// ========================================
	// Helpers
	// ========================================
	function automatic wordT byteReverse(input wordT w);
		wordT r;
		for (int b = 0; b < 4; b++) begin
			r[8*b +: 8] = w[8*(3-b) +: 8];
		end
		return r;
	endfunction

	function automatic wordT programWordAt(input wordAddrT addr);
		if (addr < progWords.size()) begin
			return progWords[addr];
		end
		return nopInstr;  // Past the end of the program
	endfunction

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic checkAddr(input string name, input wordAddrT expected, input wordAddrT actual);
		if (actual !== expected) begin
			stopWithFailure($sformatf("Error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic checkWord(input string name, input wordT expected, input wordT actual);
		if (actual !== expected) begin
			stopWithFailure($sformatf("Error: %s expected %h actual %h", name, expected, actual));
		end
	endtask

	// ========================================
	// Instruction memory and store monitor
	// ========================================
	always @(posedge clk) begin : instMemModel
		int gap;
		gap = stallDraw[drawIdx];
		if (!rst_n) begin
			instStall <= 1'b1;
			stallLeft <= 0;
		end else if (instStall && stallLeft == 0) begin
			instRdata <= byteReverse(programWordAt(instAddr));  // Bus is little endian
			instStall <= 1'b0;
		end else if (instStall) begin
			stallLeft <= stallLeft - 1;
		end else begin
			// Word taken at this edge
			drawIdx = (drawIdx + 1) % 1024;
			if (gap == 0) begin
				instRdata <= byteReverse(programWordAt(instAddr + wordAddrT'(1)));
			end else begin
				instStall <= 1'b1;
				stallLeft <= gap - 1;  // 1 to 4 stalled cycles
			end
		end
	end

	always @(negedge clk) begin
		if (i_rvCore.i_rvCoreProperties.failCount != 0) begin
			stopWithFailure("A bound assertion on the core ports failed");
		end else if (rst_n && dataWen === 1'b1) begin
			if (storeCount >= expAddr.size()) begin
				stopWithFailure("A store appeared after the last expected store");
			end else begin
				checkAddr($sformatf("store %0d address", storeCount), expAddr[storeCount], dataAddr);
				checkWord($sformatf("store %0d data", storeCount),
					byteReverse(expData[storeCount]), dataWdata);
				storeCount++;
			end
		end
	end

	initial begin
		int   fd;
		int   waited;
		string line;
		wordT word;
		wordT byteAddr;
		rst_n = 1'b0;
		void'($urandom(32'hb5b3_39a0));
		for (int i = 0; i < 1024; i++) begin
			stallDraw[i] = $urandom_range(4, 0);
		end
		fd = $fopen("tests/rvCore_stim.txt", "r");
		if (fd == 0) begin
			stopWithFailure("Could not open the stimulus file tests/rvCore_stim.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if ($sscanf(line, "I %h", word) == 1) begin
				progWords.push_back(word);
			end else if ($sscanf(line, "S %h %h", byteAddr, word) == 2) begin
				expAddr.push_back(byteAddr[31:2]);
				expData.push_back(word);
			end
		end
		$fclose(fd);
		if (expAddr.size() == 0) begin
			stopWithFailure("The stimulus file holds no expected stores");
		end

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		checkAddr("reset pc", wordAddrT'(0), instAddr);

		waited = 0;
		while (storeCount < expAddr.size() && waited < 3000) begin
			@(posedge clk);
			waited++;
		end
		if (storeCount < expAddr.size()) begin
			stopWithFailure($sformatf("Timeout with %0d of %0d stores seen",
				storeCount, expAddr.size()));
		end
		repeat (40) @(posedge clk);  // Nop tail with no further stores

		if (storeCount == expAddr.size()) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			stopWithFailure("The store count changed after the program ended");
		end
	end

endmodule

/* tests/rvCore_stim.txt */
# I <instruction word, hex, big-endian as written>
# S <store byte address, hex> <store data as held in the register, hex>
I 00500093  # addi x1, x0, 5
I FFD00113  # addi x2, x0, -3
I 002081B3  # add  x3, x1, x2   back to back with x2
I 40208233  # sub  x4, x1, x2
I 10302023  # sw   x3, 0x100(x0)
S 00000100 00000002
I 10402223  # sw   x4, 0x104(x0)
S 00000104 00000008
I 001122B3  # slt  x5, x2, x1
I 00129333  # sll  x6, x5, x1
I 405153B3  # sra  x7, x2, x5
I 00734433  # xor  x8, x6, x7
I 10802423  # sw   x8, 0x108(x0)
S 00000108 FFFFFFDE
I 12300493  # addi x9, x0, 0x123
I 01449493  # slli x9, x9, 20
I 4564E493  # ori  x9, x9, 0x456
I 10902623  # sw   x9, 0x10C(x0)
S 0000010C 12300456
I 40115513  # srai x10, x2, 1
I 00115593  # srli x11, x2, 1
I 00B54633  # xor  x12, x10, x11
I 0014D6B3  # srl  x13, x9, x1
I 00D66733  # or   x14, x12, x13
I 10E02823  # sw   x14, 0x110(x0)
S 00000110 80918022
I 0024F7B3  # and  x15, x9, x2
I FFF7C793  # xori x15, x15, -1
I 7F07F813  # andi x16, x15, 0x7F0
I FFE12893  # slti x17, x2, -2
I 01180933  # add  x18, x16, x17
I 11202A23  # sw   x18, 0x114(x0)
S 00000114 000003A1
I 00708013  # addi x0, x1, 7   must not change x0
I 10002C23  # sw   x0, 0x118(x0)
S 00000118 00000000

/* vlog.f */
design/rvPkg.sv
design/pipeStage.sv
design/rvFetch.sv
design/rvDecode.sv
design/rvRegFile.sv
design/rvExecute.sv
design/rvCore.sv
tests/rvCore_properties.sv
tests/rvCoreTb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - files:
      - design/rvPkg.sv
      - design/pipeStage.sv
      - design/rvFetch.sv
      - design/rvDecode.sv
      - design/rvRegFile.sv
      - design/rvExecute.sv
      - design/rvCore.sv
  - target: test
    files:
      - tests/rvCore_properties.sv
      - tests/rvCoreTb.sv
